/* hw/rv32c_pkg.sv */
`default_nettype none

package rv32c_pkg;

    // ======================================================================
    // fetch geometry
    // ======================================================================

    // one fetch word carries four parcels, so four slots and four lanes
    localparam int FETCH_PARCELS    = 4;
    localparam int PARCEL_WIDTH     = 16;
    localparam int FETCH_WIDTH      = FETCH_PARCELS * PARCEL_WIDTH;
    localparam int INSTR_WIDTH      = 32;
    // holds a count of 0 to 4 valid instructions
    localparam int SLOT_COUNT_WIDTH = 3;

    // ======================================================================
    // base ISA opcodes and fixed instruction words
    // ======================================================================

    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] LUI    = 7'b0110111;

    // csrrw x0, cycle, x0 faults as illegal, since cycle is read-only
    localparam logic [31:0] UNIMP  = 32'hc000_1073;
    // addi x0, x0, 0
    localparam logic [31:0] NOP    = 32'h0000_0013;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    // ======================================================================
    // field builders shared by the expansion functions
    // ======================================================================

    // the 3-bit register fields reach only x8 to x15
    function automatic logic [4:0] creg(input logic [2:0] r);
        return {2'b01, r};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    // ======================================================================
    // per-format expansion
    // ======================================================================

    // c.addi4spn, whose immediate is a zero-extended multiple of 4
    function automatic logic [31:0] decompress_ciw(input logic [15:0] c);
        logic [9:0] imm;
        imm = {c[10:7], c[12:11], c[5], c[6], 2'b00};
        // a zero immediate is reserved
        if (imm == '0)
            return UNIMP;
        return itype({2'b00, imm}, 5'd2, 3'b000, creg(c[4:2]), OP_IMM);
    endfunction

    // c.lw only, as there is no FP unit behind this fetch path
    function automatic logic [31:0] decompress_cl(input logic [15:0] c);
        logic [6:0] off;
        off = {c[5], c[12:10], c[6], 2'b00};
        if (c[15:13] != 3'b010)
            return UNIMP;
        return itype({5'b0, off}, creg(c[9:7]), 3'b010, creg(c[4:2]), LOAD);
    endfunction

    // c.sw, which has the same offset layout as c.lw
    function automatic logic [31:0] decompress_cs(input logic [15:0] c);
        logic [6:0] off;
        off = {c[5], c[12:10], c[6], 2'b00};
        if (c[15:13] != 3'b110)
            return UNIMP;
        return stype({5'b0, off}, creg(c[4:2]), creg(c[9:7]), 3'b010);
    endfunction

    // c.sub, c.xor, c.or and c.and, where rd' is also rs1'
    function automatic logic [31:0] decompress_ca(input logic [15:0] c);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'b0000000;
        case (c[6:5])
            2'b00: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            2'b01:   f3 = 3'b100;
            2'b10:   f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        // with bit 12 set these are the RV64 word forms
        if (c[12])
            return UNIMP;
        return rtype(f7, creg(c[4:2]), creg(c[9:7]), f3, creg(c[9:7]));
    endfunction

    // c.beqz and c.bnez compare against x0, and c.andi shares the layout
    function automatic logic [31:0] decompress_cb(input logic [15:0] c);
        logic [12:0] boff;
        logic [11:0] imm;
        boff = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        imm  = {{6{c[12]}}, c[12], c[6:2]};
        case (c[15:13])
            3'b100: begin
                if (c[11:10] != 2'b10)
                    return UNIMP;
                return itype(imm, creg(c[9:7]), 3'b111, creg(c[9:7]), OP_IMM);
            end
            // funct3 bit 13 picks bne over beq
            3'b110, 3'b111:
                return {boff[12], boff[10:5], 5'd0, creg(c[9:7]), {2'b00, c[13]},
                        boff[4:1], boff[11], BRANCH};
            default: return UNIMP;
        endcase
    endfunction

    // c.j links to x0 and c.jal links to x1
    function automatic logic [31:0] decompress_cj(input logic [15:0] c);
        logic [20:0] off;
        off = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        if (c[14:13] != 2'b01)
            return UNIMP;
        return {off[20], off[10:1], off[11], off[19:12], (c[15] ? 5'd0 : 5'd1), JAL};
    endfunction

    // c.nop, c.addi, c.li, c.lui, c.addi16sp, c.srli, c.srai and c.slli
    function automatic logic [31:0] decompress_ci_arith(input logic [15:0] c);
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [9:0]  imm16;
        rd    = c[11:7];
        imm   = {{6{c[12]}}, c[12], c[6:2]};
        imm16 = {c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
        case ({c[15:13], c[1:0]})
            5'b000_01: begin
                // rd of x0 is c.nop and its hints
                if (rd == 5'd0)
                    return NOP;
                return itype(imm, rd, 3'b000, rd, OP_IMM);
            end
            5'b010_01: return itype(imm, 5'd0, 3'b000, rd, OP_IMM);
            5'b011_01: begin
                // rd of x2 turns c.lui into c.addi16sp
                if (rd == 5'd2) begin
                    if (imm16 == '0)
                        return UNIMP;
                    return itype({{2{imm16[9]}}, imm16}, 5'd2, 3'b000, 5'd2, OP_IMM);
                end
                if (imm[5:0] == '0)
                    return UNIMP;
                return {{14{c[12]}}, c[12], c[6:2], rd, LUI};
            end
            5'b100_01: begin
                // shamt bit 5 is reserved on RV32, and bit 11 marks c.andi or CA forms
                if (c[12] || c[11])
                    return UNIMP;
                // bit 10 lands on funct7 bit 5, which gives srai instead of srli
                return itype({1'b0, c[10], 5'b00000, c[6:2]}, creg(c[9:7]), 3'b101,
                             creg(c[9:7]), OP_IMM);
            end
            5'b000_10: begin
                if (c[12])
                    return UNIMP;
                return itype({7'b0000000, c[6:2]}, rd, 3'b001, rd, OP_IMM);
            end
            default: return UNIMP;
        endcase
    endfunction

    // c.lwsp, where an rd of x0 is reserved
    function automatic logic [31:0] decompress_ci_load(input logic [15:0] c);
        logic [7:0] off;
        off = {c[3:2], c[12], c[6:4], 2'b00};
        if (c[15:13] != 3'b010 || c[11:7] == 5'd0)
            return UNIMP;
        return itype({4'b0000, off}, 5'd2, 3'b010, c[11:7], LOAD);
    endfunction

    // c.swsp
    function automatic logic [31:0] decompress_ci_store(input logic [15:0] c);
        logic [7:0] off;
        off = {c[8:7], c[12:9], 2'b00};
        if (c[15:13] != 3'b110)
            return UNIMP;
        return stype({4'b0000, off}, c[6:2], 5'd2, 3'b010);
    endfunction

    // c.jr, c.mv, c.ebreak, c.jalr and c.add share funct3 100
    function automatic logic [31:0] decompress_cr(input logic [15:0] c);
        logic [4:0] rs1;
        logic [4:0] rs2;
        rs1 = c[11:7];
        rs2 = c[6:2];
        if (rs2 != 5'd0)
            return c[12] ? rtype(7'b0, rs2, rs1, 3'b000, rs1)
                         : rtype(7'b0, rs2, 5'd0, 3'b000, rs1);
        // c.jr with rs1 of x0 is reserved
        if (rs1 == 5'd0)
            return c[12] ? EBREAK : UNIMP;
        return itype(12'd0, rs1, 3'b000, (c[12] ? 5'd1 : 5'd0), JALR);
    endfunction

endpackage

`default_nettype wire

/* hw/decompressor.sv */
`default_nettype none

// expands one compressed parcel into its 32-bit base form
// purely combinational, so a lane adds no cycle
module decompressor (
    input  wire  [rv32c_pkg::PARCEL_WIDTH-1:0] compressed,
    output logic [rv32c_pkg::INSTR_WIDTH-1:0]  decompressed
);

    // dispatch on funct3 and the quadrant bits
    always_comb begin
        case ({compressed[15:13], compressed[1:0]})
            // quadrant 0
            5'b000_00: begin
                // the all-zero parcel is defined as illegal
                if (compressed == '0)
                    decompressed = rv32c_pkg::UNIMP;
                else
                    decompressed = rv32c_pkg::decompress_ciw(compressed);
            end
            5'b001_00, 5'b010_00, 5'b011_00:
                decompressed = rv32c_pkg::decompress_cl(compressed);
            5'b100_00: decompressed = rv32c_pkg::UNIMP;
            5'b101_00, 5'b110_00, 5'b111_00:
                decompressed = rv32c_pkg::decompress_cs(compressed);

            // quadrant 1
            5'b000_01, 5'b010_01, 5'b011_01:
                decompressed = rv32c_pkg::decompress_ci_arith(compressed);
            5'b100_01: begin
                // bits 11:10 split register ops, c.andi and the shifts
                if (compressed[11:10] == 2'b11)
                    decompressed = rv32c_pkg::decompress_ca(compressed);
                else if (compressed[11:10] == 2'b10)
                    decompressed = rv32c_pkg::decompress_cb(compressed);
                else
                    decompressed = rv32c_pkg::decompress_ci_arith(compressed);
            end
            5'b001_01, 5'b101_01: decompressed = rv32c_pkg::decompress_cj(compressed);
            5'b110_01, 5'b111_01: decompressed = rv32c_pkg::decompress_cb(compressed);

            // quadrant 2
            5'b000_10: decompressed = rv32c_pkg::decompress_ci_arith(compressed);
            5'b001_10, 5'b010_10, 5'b011_10:
                decompressed = rv32c_pkg::decompress_ci_load(compressed);
            5'b100_10: decompressed = rv32c_pkg::decompress_cr(compressed);
            5'b101_10, 5'b110_10, 5'b111_10:
                decompressed = rv32c_pkg::decompress_ci_store(compressed);

            // quadrant 3 is a full-size word, which the packer never takes from a lane
            default: decompressed = rv32c_pkg::UNIMP;
        endcase
    end

endmodule

`default_nettype wire

/* hw/parcel_aligner.sv */
`default_nettype none

// finds instruction boundaries in a fetch word and fills up to four slots
// the low half of a 32-bit instruction in parcel 3 waits for the next fetch
module parcel_aligner (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    fetch_valid,
    input  wire                                    flush,
    input  wire  [rv32c_pkg::FETCH_WIDTH-1:0]      fetch_data,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0]    slot_valid,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0] slot_raw,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0]    slot_rvc
);

    // carried lower half from the previous fetch
    logic                                carry_valid;
    logic [rv32c_pkg::PARCEL_WIDTH-1:0]  carry_half;

    // next-state slot contents from the walk
    logic [rv32c_pkg::FETCH_PARCELS-1:0]                               valid_n;
    logic [rv32c_pkg::FETCH_PARCELS-1:0]                               rvc_n;
    logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0]   raw_n;

    // walk state, where half ends up as the carry out of the word
    logic                                half_valid;
    logic [rv32c_pkg::PARCEL_WIDTH-1:0]  half;
    logic [rv32c_pkg::PARCEL_WIDTH-1:0]  parcel;
    logic [1:0]                          idx;

    // ======================================================================
    // boundary walk
    // ======================================================================

    always_comb begin
        valid_n = '0;
        rvc_n   = '0;
        raw_n   = '0;
        // a flush in the same cycle drops the carry before the walk starts
        half_valid = carry_valid && !flush;
        half       = carry_half;
        idx        = '0;
        for (int i = 0; i < rv32c_pkg::FETCH_PARCELS; i++) begin
            parcel = fetch_data[i*rv32c_pkg::PARCEL_WIDTH +: rv32c_pkg::PARCEL_WIDTH];
            if (half_valid) begin
                // this parcel is the upper half of a pending 32-bit word
                raw_n[idx]   = {parcel, half};
                valid_n[idx] = 1'b1;
                half_valid   = 1'b0;
                idx          = idx + 2'd1;
            end else if (parcel[1:0] != 2'b11) begin
                // compressed, kept in the low half of its slot
                raw_n[idx]   = {16'h0000, parcel};
                valid_n[idx] = 1'b1;
                rvc_n[idx]   = 1'b1;
                idx          = idx + 2'd1;
            end else begin
                half       = parcel;
                half_valid = 1'b1;
            end
        end
        // each parcel ends at most one slot, so idx only wraps after the last write
    end

    // ======================================================================
    // slot and carry registers
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid  <= '0;
            carry_valid <= 1'b0;
        end else begin
            slot_valid <= fetch_valid ? valid_n : '0;
            if (fetch_valid)
                carry_valid <= half_valid;
            else if (flush)
                carry_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        slot_raw <= raw_n;
        slot_rvc <= rvc_n;
        if (fetch_valid)
            carry_half <= half;
    end

endmodule

`default_nettype wire

/* hw/instr_packer.sv */
`default_nettype none

// picks the expanded or raw word per slot and packs valid slots to word 0
module instr_packer (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire  [rv32c_pkg::FETCH_PARCELS-1:0]    slot_valid,
    input  wire  [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0] slot_raw,
    input  wire  [rv32c_pkg::FETCH_PARCELS-1:0]    slot_rvc,
    input  wire  [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0] lane_expanded,
    output logic                                   out_valid,
    output logic [rv32c_pkg::SLOT_COUNT_WIDTH-1:0] out_count,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0] out_instr,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0]    out_rvc
);

    logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0]  packed_n;
    logic [rv32c_pkg::FETCH_PARCELS-1:0]                              rvc_n;
    logic [rv32c_pkg::SLOT_COUNT_WIDTH-1:0]                           count_n;
    logic [rv32c_pkg::INSTR_WIDTH-1:0]                                word;

    // ======================================================================
    // select and compaction
    // ======================================================================

    always_comb begin
        packed_n = '0;
        rvc_n    = '0;
        count_n  = '0;
        for (int i = 0; i < rv32c_pkg::FETCH_PARCELS; i++) begin
            // the lane output is meaningful only for compressed slots
            word = slot_rvc[i] ? lane_expanded[i] : slot_raw[i];
            if (slot_valid[i]) begin
                // count_n is the next free packed word
                packed_n[count_n[1:0]] = word;
                rvc_n[count_n[1:0]]    = slot_rvc[i];
                count_n                = count_n + 3'd1;
            end
        end
    end

    // ======================================================================
    // output register
    // ======================================================================

    // a processed fetch always fills slot 0, either from the carry or from
    // parcel 0, so any valid slot marks a group that must be emitted
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_count <= '0;
        end else begin
            out_valid <= |slot_valid;
            out_count <= count_n;
        end
    end

    always_ff @(posedge clk) begin
        out_instr <= packed_n;
        out_rvc   <= rvc_n;
    end

endmodule

`default_nettype wire

/* hw/rvc_fetch_expander.sv */
`default_nettype none

// compressed-instruction expansion stage of the fetch path
// a fetch sampled on edge k leaves the packer after edge k+1
module rvc_fetch_expander (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    fetch_valid,
    input  wire                                    flush,
    input  wire  [rv32c_pkg::FETCH_WIDTH-1:0]      fetch_data,
    output logic                                   out_valid,
    output logic [rv32c_pkg::SLOT_COUNT_WIDTH-1:0] out_count,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0] out_instr,
    output logic [rv32c_pkg::FETCH_PARCELS-1:0]    out_rvc
);

    // aligner to lanes and packer
    logic [rv32c_pkg::FETCH_PARCELS-1:0]                              slot_valid;
    logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0]  slot_raw;
    logic [rv32c_pkg::FETCH_PARCELS-1:0]                              slot_rvc;
    // lanes to packer
    logic [rv32c_pkg::FETCH_PARCELS-1:0][rv32c_pkg::INSTR_WIDTH-1:0]  lane_expanded;

    parcel_aligner u_aligner (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .flush       (flush),
        .fetch_data  (fetch_data),
        .slot_valid  (slot_valid),
        .slot_raw    (slot_raw),
        .slot_rvc    (slot_rvc)
    );

    // ======================================================================
    // one decompressor per slot, all four expanding in parallel
    // ======================================================================

    for (genvar g = 0; g < rv32c_pkg::FETCH_PARCELS; g++) begin : g_lane
        decompressor u_decomp (
            .compressed   (slot_raw[g][rv32c_pkg::PARCEL_WIDTH-1:0]),
            .decompressed (lane_expanded[g])
        );
    end

    instr_packer u_packer (
        .clk           (clk),
        .rst           (rst),
        .slot_valid    (slot_valid),
        .slot_raw      (slot_raw),
        .slot_rvc      (slot_rvc),
        .lane_expanded (lane_expanded),
        .out_valid     (out_valid),
        .out_count     (out_count),
        .out_instr     (out_instr),
        .out_rvc       (out_rvc)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`default_nettype none

// free-running clock and a synchronous reset that is held for the first few edges
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS    = 10;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on the third rising edge, in step with the DUT registers
    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tb_rvc_fetch_expander.sv */
`default_nettype none

module tb_rvc_fetch_expander;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS     = 10;
    localparam int RAND_COUNT   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 4;
    localparam int MARGIN       = 20;
    localparam int TIMEOUT_NS   =
        (NUM_ROWS + RAND_COUNT + RESET_CYCLES + IDLE_CYCLES + MARGIN) * 10;
    localparam logic [31:0] SEED = 32'h9ded3ac1;

    logic         clk;
    logic         rst;
    logic         fetch_valid;
    logic         flush;
    logic [63:0]  fetch_data;
    logic         out_valid;
    logic [2:0]   out_count;
    logic [127:0] out_instr;
    logic [3:0]   out_rvc;

    // stimulus table, one fetch or flush-only cycle per row
    string        row_name  [NUM_ROWS];
    logic         row_valid [NUM_ROWS];
    logic         row_flush [NUM_ROWS];
    logic [63:0]  row_fetch [NUM_ROWS];
    logic [2:0]   row_count [NUM_ROWS];
    logic [127:0] row_instr [NUM_ROWS];
    logic [3:0]   row_rvc   [NUM_ROWS];

    // expected groups in arrival order, keyed by the falling edge they are due on
    int           exp_at    [$];
    string        exp_name  [$];
    logic [2:0]   exp_count [$];
    logic [127:0] exp_instr [$];
    logic [3:0]   exp_rvc   [$];

    int neg_count       = 0;
    int checks          = 0;
    int value_errors    = 0;
    int protocol_errors = 0;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    rvc_fetch_expander dut0 (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .flush       (flush),
        .fetch_data  (fetch_data),
        .out_valid   (out_valid),
        .out_count   (out_count),
        .out_instr   (out_instr),
        .out_rvc     (out_rvc)
    );

    // ======================================================================
    // helpers
    // ======================================================================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic valid,
                           input logic flsh, input logic [63:0] fetch, input logic [2:0] count,
                           input logic [127:0] instr, input logic [3:0] rvc);
        row_name[idx]  = name;
        row_valid[idx] = valid;
        row_flush[idx] = flsh;
        row_fetch[idx] = fetch;
        row_count[idx] = count;
        row_instr[idx] = instr;
        row_rvc[idx]   = rvc;
    endtask

    // called on a rising edge, the group is due three falling edges later
    task automatic expect_group(input string name, input logic [2:0] count,
                                input logic [127:0] instr, input logic [3:0] rvc);
        exp_at.push_back(neg_count + 3);
        exp_name.push_back(name);
        exp_count.push_back(count);
        exp_instr.push_back(instr);
        exp_rvc.push_back(rvc);
    endtask

    // expansions below were worked out by hand from the RVC encoding tables
    task automatic load_table();
        // c.addi x10,5 / c.lw x9,4(x8) / c.sw x9,8(x8) / c.j +8
        set_row(0, "four compressed a", 1'b1, 1'b0, 64'ha021_c404_4044_0515, 3'd4,
                128'h0080006f_00942423_00442483_00550513, 4'b1111);
        // c.add x10,x11 / c.beqz x8,+4 / c.lwsp x10,8(sp) / c.addi4spn x8,16
        set_row(1, "four compressed b", 1'b1, 1'b0, 64'h0800_4522_c011_952e, 3'd4,
                128'h01010413_00812503_00040263_00b50533, 4'b1111);
        // three compressed, then the low half of lui x5,0x12345 in parcel 3
        set_row(2, "straddle start", 1'b1, 1'b0, 64'h52b7_4522_952e_0515, 3'd3,
                128'h00000000_00812503_00b50533_00550513, 4'b0111);
        // upper half of the lui, add x5,x6,x7, then c.sw
        set_row(3, "straddle finish", 1'b1, 1'b0, 64'hc404_0073_02b3_1234, 3'd3,
                128'h00000000_00942423_007302b3_123452b7, 4'b0100);
        set_row(4, "straddle before flush", 1'b1, 1'b0, 64'h52b7_4522_952e_0515, 3'd3,
                128'h00000000_00812503_00b50533_00550513, 4'b0111);
        set_row(5, "flush only", 1'b0, 1'b1, 64'h0, 3'd0, 128'h0, 4'b0000);
        // parcel 0 is now a c.addi4spn x13,296 of its own
        set_row(6, "fresh after flush", 1'b1, 1'b0, 64'h4044_c011_a021_1234, 3'd4,
                128'h00442483_00040263_0080006f_12810693, 4'b1111);
        set_row(7, "straddle before joint flush", 1'b1, 1'b0, 64'h52b7_4522_952e_0515, 3'd3,
                128'h00000000_00812503_00b50533_00550513, 4'b0111);
        set_row(8, "flush with fetch", 1'b1, 1'b1, 64'h4044_c011_a021_1234, 3'd4,
                128'h00442483_00040263_0080006f_12810693, 4'b1111);
        // zero parcel, c.addi4spn with zero immediate, reserved quadrant 0, c.nop
        set_row(9, "illegal encodings", 1'b1, 1'b0, 64'h0001_8000_0004_0000, 3'd4,
                128'h00000013_c0001073_c0001073_c0001073, 4'b1111);
    endtask

    // ======================================================================
    // output monitor, sampling in the middle of the cycle
    // ======================================================================

    always @(negedge clk) begin
        neg_count = neg_count + 1;
        if (!rst) begin
            if (exp_at.size() > 0 && exp_at[0] == neg_count) begin
                if (!out_valid) begin
                    $display("out_valid missing at the fixed latency for %s", exp_name[0]);
                    protocol_errors++;
                end else begin
                    check_value({exp_name[0], " out_count"}, {125'b0, exp_count[0]},
                                {125'b0, out_count});
                    check_value({exp_name[0], " out_instr"}, exp_instr[0], out_instr);
                    check_value({exp_name[0], " out_rvc"}, {124'b0, exp_rvc[0]},
                                {124'b0, out_rvc});
                end
                void'(exp_at.pop_front());
                void'(exp_name.pop_front());
                void'(exp_count.pop_front());
                void'(exp_instr.pop_front());
                void'(exp_rvc.pop_front());
            end else if (out_valid) begin
                $display("out_valid raised with no group due at %0t", $time);
                protocol_errors++;
            end else begin
                // an idle output holds a zero count
                check_value("idle out_count", 128'd0, {125'b0, out_count});
            end
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    initial begin
        logic [31:0] lcg_state;
        logic [31:0] w0;
        logic [31:0] w1;
        fetch_valid <= 1'b0;
        flush       <= 1'b0;
        fetch_data  <= '0;
        lcg_state = SEED;
        load_table();
        // rst is still unknown at time zero, so wait for a definite low
        while (rst !== 1'b0)
            @(negedge clk);
        // a few quiet cycles so the monitor sees the post-reset idle state
        repeat (IDLE_CYCLES) @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            fetch_valid <= row_valid[r];
            flush       <= row_flush[r];
            fetch_data  <= row_fetch[r];
            if (row_valid[r])
                expect_group(row_name[r], row_count[r], row_instr[r], row_rvc[r]);
        end
        // two full-size words per fetch, one fetch every cycle
        for (int n = 0; n < RAND_COUNT; n++) begin
            lcg_state = lcg_step(lcg_state);
            w0 = lcg_state | 32'h3;
            lcg_state = lcg_step(lcg_state);
            w1 = lcg_state | 32'h3;
            @(posedge clk);
            fetch_valid <= 1'b1;
            flush       <= 1'b0;
            fetch_data  <= {w1, w0};
            expect_group($sformatf("random %0d", n), 3'd2, {64'h0, w1, w0}, 4'b0000);
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        fetch_data  <= '0;
        while (exp_at.size() != 0)
            @(posedge clk);
        // a short tail catches any stray strobe
        repeat (3) @(posedge clk);
        $display("summary: %0d checks, %0d value errors, %0d protocol errors",
                 checks, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // watchdog sized from the reset, the table and the random phase
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns with %0d groups still outstanding",
                 TIMEOUT_NS, exp_at.size());
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/rv32c_pkg.sv
hw/decompressor.sv
hw/parcel_aligner.sv
hw/instr_packer.sv
hw/rvc_fetch_expander.sv
tests/tb_clock_gen.sv
tests/tb_rvc_fetch_expander.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fetch expander testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_rvc_fetch_expander \
    -f files.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
